//--- project.f
+incdir+.
motion_pkg.sv
endstop_debounce.sv
axis_router.sv
step_pulse_gen.sv
motion_regs.sv
motion_top.sv
tb_motion_top.sv

//--- Bender.yml
package:
  name: motion_ctrl

sources:
  - motion_pkg.sv
  - endstop_debounce.sv
  - axis_router.sv
  - step_pulse_gen.sv
  - motion_regs.sv
  - motion_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_motion_top.sv

//--- tb_motion_cases.svh
`ifndef tb_motion_cases_svh
`define tb_motion_cases_svh

typedef enum int {
    act_none,
    act_preset,
    act_lock,
    act_glitch
} case_act_e;

typedef struct packed {
    int               mot;         // motor under test
    logic [cfg_w-1:0] cfg;
    int               pre;         // upper bounds for the random pulse counts
    int               pul;
    int               post;
    int               ch;
    logic             dir;
    int               nstb;        // strobes per burst
    case_act_e        act;
    int               tmo;         // es_timeout
    int               xv;          // preset value
    int               delta;       // total position change over the case
    logic             en;
    logic             mdir;        // motor_dir at the end
    int               hold_ofs;    // hold position relative to case start
    logic [3:0]       abort_mask;  // channels whose abort pulses once
} case_row_t;

localparam int num_cases = 9;

// mot cfg pre pul post ch dir nstb act tmo xv delta en mdir hold_ofs abort_mask
localparam case_row_t cases [num_cases] = '{
    '{0, 16'h0048, 3, 2, 2, 1, 1'b1, 3, act_none,   4,   0,  3, 1'b1, 1'b1, 0, 4'h0},
    '{1, 16'h00d1, 1, 1, 0, 2, 1'b1, 2, act_none,   4,   0, -2, 1'b1, 1'b0, 0, 4'h0},
    '{2, 16'h00da, 0, 3, 1, 3, 1'b0, 2, act_none,   4,   0,  2, 1'b1, 1'b1, 0, 4'h0},
    '{3, 16'h8003, 2, 1, 1, 0, 1'b1, 2, act_none,   4,   0,  0, 1'b0, 1'b0, 0, 4'h0},
    '{0, 16'h0248, 2, 2, 1, 1, 1'b0, 1, act_preset, 4, 100, -1, 1'b1, 1'b0, 0, 4'h0},
    '{1, 16'h00d1, 1, 2, 2, 2, 1'b0, 1, act_preset, 4,  55,  1, 1'b1, 1'b1, 0, 4'h0},
    '{2, 16'h015a, 2, 2, 2, 3, 1'b1, 2, act_lock,   5,   0,  4, 1'b1, 1'b1, 2, 4'h8},
    '{0, 16'h0049, 1, 1, 1, 1, 1'b1, 1, act_lock,   3,   0,  2, 1'b1, 1'b1, 1, 4'h0},
    '{3, 16'h0143, 2, 3, 2, 0, 1'b1, 2, act_glitch, 6,   0,  4, 1'b1, 1'b1, 0, 4'h0}
};

`endif

//--- tb_motion_top.sv
`timescale 1ns/1ns

module tb_motion_top import motion_pkg::*; ();

    logic                              clk;
    logic                              reset;
    logic                              reg_wr;
    reg_addr_e                         reg_addr;
    logic [data_w-1:0]                 reg_wdata;
    logic                              cmd_set_x;
    logic                              cmd_unlock;
    logic [num_channels-1:0]           src_step;
    logic [num_channels-1:0]           src_dir;
    logic [num_endstops-1:0]           endstop;
    logic [num_motors-1:0]             motor_step;
    logic [num_motors-1:0]             motor_dir;
    logic [num_motors-1:0]             motor_enable;
    logic [num_motors-1:0][data_w-1:0] motor_pos;
    logic [num_motors-1:0][data_w-1:0] motor_hold_pos;
    logic [num_channels-1:0]           es_abort;
    logic [num_endstops-1:0]           es_state;

    `include "tb_motion_cases.svh"

    int model_pos [num_motors];
    int model_hold [num_motors];
    int abort_total [num_channels];  // abort pulse cycles per channel
    int error_count;
    int pass_cnt;
    int fail_cnt;
    int cycles;
    int cycle_limit;

    motion_top i_dut (.*);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        for (int c = 0; c < num_channels; c++) begin
            abort_total[c] += es_abort[c];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic int cycle_budget();
        int total;
        total = 10;
        for (int r = 0; r < num_cases; r++) begin
            total += 3 * cases[r].nstb * (cases[r].pre + cases[r].pul + cases[r].post + 3);
            total += 3 * (cases[r].tmo + sync_stages + 4) + 30;  // debounce and setup
        end
        return 2 * total;
    endfunction

    // other motors listen to the next channel and endstop
    function automatic logic [cfg_w-1:0] bystander_cfg(input int ch, input int es);
        logic [cfg_w-1:0] c;
        c = '0;
        c[cfg_step_en] = 1'b1;
        c[cfg_src_sel_lsb +: sel_w] = sel_w'((ch + 1) % num_channels);
        c[cfg_es_sel_lsb +: sel_w]  = sel_w'((es + 1) % num_endstops);
        return c;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [data_w-1:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic issue_strobe(input case_row_t row, input bit expect_step, input int pre,
                                input int pul, input int post);
        int rise_at;
        int high_cnt;
        rise_at  = 0;
        high_cnt = 0;
        @(negedge clk);
        src_step[row.ch] = 1'b1;
        for (int i = 1; i <= pre + pul + post + 2; i++) begin
            @(negedge clk);
            src_step[row.ch] = 1'b0;
            if (motor_step[row.mot]) begin
                if (rise_at == 0) begin
                    rise_at = i;  // rising edges since the strobe
                end
                high_cnt++;
            end
        end
        if (expect_step) begin
            compare_value($sformatf("motor_step[%0d] rise edge", row.mot), rise_at, pre + 1);
        end
        compare_value($sformatf("motor_step[%0d] high cycles", row.mot), high_cnt,
                      expect_step ? pul : 0);
    endtask

    task automatic run_case(input int r);
        case_row_t row;
        int        pre;
        int        pul;
        int        post;
        int        es;
        int        start;
        int        errs_before;
        int        abort_base [num_channels];
        bit        step_en;
        row         = cases[r];
        errs_before = error_count;
        pre         = $urandom_range(row.pre, 0);
        pul         = $urandom_range(row.pul, 1);
        post        = $urandom_range(row.post, 0);
        es          = row.cfg[cfg_es_sel_lsb +: sel_w];
        step_en     = row.cfg[cfg_step_en];
        for (int m = 0; m < num_motors; m++) begin
            write_reg(reg_addr_e'(reg_motor_cfg0 + m),
                      (m == row.mot) ? row.cfg : bystander_cfg(row.ch, es));
        end
        write_reg(reg_pre_n, pre);
        write_reg(reg_pulse_n, pul);
        write_reg(reg_post_n, post);
        write_reg(reg_es_timeout, row.tmo);
        src_dir[row.ch] = row.dir;
        abort_base = abort_total;
        if (row.act == act_preset) begin
            write_reg(reg_x_val, row.xv);
            cmd_set_x = 1'b1;
            @(negedge clk);
            cmd_set_x = 1'b0;
            if (row.cfg[cfg_set_x_en]) begin
                model_pos[row.mot] = row.xv;
            end
        end
        start = model_pos[row.mot];
        repeat (row.nstb) issue_strobe(row, step_en, pre, pul, post);
        if (row.act == act_lock) begin
            endstop[es] = 1'b1;
            repeat (row.tmo + sync_stages + 3) @(negedge clk);
            compare_value($sformatf("es_state[%0d]", es), es_state[es], 1'b1);
            model_hold[row.mot] = start + row.hold_ofs;
            repeat (row.nstb) issue_strobe(row, 1'b0, pre, pul, post);  // held
            endstop[es] = 1'b0;
            repeat (row.tmo + sync_stages + 3) @(negedge clk);
            cmd_unlock = 1'b1;
            @(negedge clk);
            cmd_unlock = 1'b0;
            repeat (row.nstb) issue_strobe(row, step_en, pre, pul, post);
        end else if (row.act == act_glitch) begin
            endstop[es] = 1'b1;
            repeat ($urandom_range(row.tmo - 1, 1)) @(negedge clk);
            endstop[es] = 1'b0;
            repeat (row.tmo + sync_stages + 3) @(negedge clk);
            compare_value($sformatf("es_state[%0d]", es), es_state[es], 1'b0);
            repeat (row.nstb) issue_strobe(row, step_en, pre, pul, post);
        end
        model_pos[row.mot] = start + row.delta;
        for (int m = 0; m < num_motors; m++) begin
            compare_value($sformatf("motor_pos[%0d]", m), motor_pos[m], model_pos[m]);
            compare_value($sformatf("motor_hold_pos[%0d]", m), motor_hold_pos[m],
                          model_hold[m]);
        end
        compare_value($sformatf("motor_enable[%0d]", row.mot), motor_enable[row.mot], row.en);
        compare_value($sformatf("motor_dir[%0d]", row.mot), motor_dir[row.mot], row.mdir);
        for (int c = 0; c < num_channels; c++) begin
            compare_value($sformatf("es_abort[%0d] pulses", c), abort_total[c] - abort_base[c],
                          row.abort_mask[c]);
        end
        if (error_count == errs_before) begin
            pass_cnt++;
            $display("test %0d, motor %0d: ok", r, row.mot);
        end else begin
            fail_cnt++;
            $display("test %0d, motor %0d: %0d errors", r, row.mot, error_count - errs_before);
        end
    endtask

    initial begin
        void'($urandom(94));
        clk         = 1'b0;
        reset       = 1'b1;
        reg_wr      = 1'b0;
        reg_addr    = reg_pre_n;
        reg_wdata   = '0;
        cmd_set_x   = 1'b0;
        cmd_unlock  = 1'b0;
        src_step    = '0;
        src_dir     = '0;
        endstop     = '0;
        error_count = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycles      = 0;
        cycle_limit = cycle_budget();
        for (int m = 0; m < num_motors; m++) begin
            model_pos[m]  = 0;
            model_hold[m] = 0;
        end
        for (int c = 0; c < num_channels; c++) begin
            abort_total[c] = 0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < num_cases; r++) begin
            run_case(r);
        end
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- motion_top.sv
`timescale 1ns/1ns

module motion_top import motion_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              reg_wr,
    input  reg_addr_e                         reg_addr,
    input  logic [data_w-1:0]                 reg_wdata,
    input  logic                              cmd_set_x,
    input  logic                              cmd_unlock,
    input  logic [num_channels-1:0]           src_step,
    input  logic [num_channels-1:0]           src_dir,
    input  logic [num_endstops-1:0]           endstop,
    output logic [num_motors-1:0]             motor_step,
    output logic [num_motors-1:0]             motor_dir,
    output logic [num_motors-1:0]             motor_enable,
    output logic [num_motors-1:0][data_w-1:0] motor_pos,
    output logic [num_motors-1:0][data_w-1:0] motor_hold_pos,
    output logic [num_channels-1:0]           es_abort,
    output logic [num_endstops-1:0]           es_state
);

    logic [data_w-1:0]                pre_n;
    logic [data_w-1:0]                pulse_n;
    logic [data_w-1:0]                post_n;
    logic [data_w-1:0]                es_timeout;
    logic [data_w-1:0]                x_val;
    logic [num_motors-1:0][cfg_w-1:0] motor_cfg;

    logic [num_endstops-1:0] es_hold;
    logic [num_endstops-1:0] es_stb;
    logic [num_motors-1:0]   mot_step_stb;
    logic [num_motors-1:0]   mot_dir;
    logic [num_motors-1:0]   mot_hold;

    motion_regs i_regs (
        .clk        (clk),
        .reset      (reset),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .pre_n      (pre_n),
        .pulse_n    (pulse_n),
        .post_n     (post_n),
        .es_timeout (es_timeout),
        .x_val      (x_val),
        .motor_cfg  (motor_cfg)
    );

    for (genvar e = 0; e < num_endstops; e++) begin : g_es
        endstop_debounce i_db (
            .clk       (clk),
            .reset     (reset),
            .signal_in (endstop[e]),
            .unlock    (cmd_unlock),
            .timeout   (es_timeout),
            .signal    (es_state[e]),
            .hold      (es_hold[e]),
            .stb       (es_stb[e])
        );
    end

    axis_router i_router (
        .motor_cfg    (motor_cfg),
        .src_step     (src_step),
        .src_dir      (src_dir),
        .es_hold      (es_hold),
        .es_stb       (es_stb),
        .mot_step_stb (mot_step_stb),
        .mot_dir      (mot_dir),
        .mot_hold     (mot_hold),
        .mot_enable   (motor_enable),
        .es_abort     (es_abort)
    );

    for (genvar m = 0; m < num_motors; m++) begin : g_motor
        step_pulse_gen i_spg (
            .clk      (clk),
            .reset    (reset),
            .pre_n    (pre_n),
            .pulse_n  (pulse_n),
            .post_n   (post_n),
            .step_stb (mot_step_stb[m]),
            .step_dir (mot_dir[m]),
            .hold     (mot_hold[m]),
            .set_x    (cmd_set_x),
            .set_x_en (motor_cfg[m][cfg_set_x_en]),
            .x_val    (x_val),
            .step     (motor_step[m]),
            .dir      (motor_dir[m]),
            .x        (motor_pos[m]),
            .x_hold   (motor_hold_pos[m])
        );
    end

endmodule

//--- motion_regs.sv
`timescale 1ns/1ns

module motion_regs import motion_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             reg_wr,
    input  reg_addr_e                        reg_addr,
    input  logic [data_w-1:0]                reg_wdata,
    output logic [data_w-1:0]                pre_n,
    output logic [data_w-1:0]                pulse_n,
    output logic [data_w-1:0]                post_n,
    output logic [data_w-1:0]                es_timeout,
    output logic [data_w-1:0]                x_val,
    output logic [num_motors-1:0][cfg_w-1:0] motor_cfg
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pre_n      <= '0;
            pulse_n    <= '0;
            post_n     <= '0;
            es_timeout <= '0;
            x_val      <= '0;
            motor_cfg  <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                reg_pre_n:      pre_n      <= reg_wdata;
                reg_pulse_n:    pulse_n    <= reg_wdata;
                reg_post_n:     post_n     <= reg_wdata;
                reg_es_timeout: es_timeout <= reg_wdata;
                reg_x_val:      x_val      <= reg_wdata;
                reg_motor_cfg0: motor_cfg[0] <= reg_wdata[cfg_w-1:0];
                reg_motor_cfg1: motor_cfg[1] <= reg_wdata[cfg_w-1:0];
                reg_motor_cfg2: motor_cfg[2] <= reg_wdata[cfg_w-1:0];
                reg_motor_cfg3: motor_cfg[3] <= reg_wdata[cfg_w-1:0];
                default: ;  // unmapped address dropped
            endcase
        end
    end

endmodule

//--- step_pulse_gen.sv
`timescale 1ns/1ns

module step_pulse_gen import motion_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [data_w-1:0] pre_n,
    input  logic [data_w-1:0] pulse_n,
    input  logic [data_w-1:0] post_n,
    input  logic              step_stb,
    input  logic              step_dir,
    input  logic              hold,
    input  logic              set_x,
    input  logic              set_x_en,
    input  logic [data_w-1:0] x_val,
    output logic              step,
    output logic              dir,
    output logic [data_w-1:0] x,
    output logic [data_w-1:0] x_hold
);

    typedef enum logic [1:0] {
        st_idle,
        st_pre,
        st_pulse,
        st_post
    } state_e;

    state_e            state;
    logic [data_w-1:0] cnt;  // cycles left in current phase
    logic              hold_q;
    logic              accept;

    assign accept = (state == st_idle) && step_stb && !hold;
    assign step   = (state == st_pulse);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
            dir   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        dir <= step_dir;
                        if (pre_n != '0) begin
                            state <= st_pre;
                            cnt   <= pre_n;
                        end else begin
                            state <= st_pulse;  // no pre delay
                            cnt   <= pulse_n;
                        end
                    end
                end
                st_pre: begin
                    if (cnt <= 1) begin
                        state <= st_pulse;
                        cnt   <= pulse_n;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_pulse: begin
                    if (cnt > 1) begin
                        cnt <= cnt - 1'b1;
                    end else if (post_n != '0) begin
                        state <= st_post;
                        cnt   <= post_n;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: begin
                    if (cnt <= 1) begin
                        state <= st_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x      <= '0;
            x_hold <= '0;
            hold_q <= 1'b0;
        end else begin
            hold_q <= hold;
            if (set_x && set_x_en) begin
                x <= x_val;  // preset wins over a step
            end else if (accept) begin
                x <= step_dir ? x + 1'b1 : x - 1'b1;
            end
            if (hold && !hold_q) begin
                x_hold <= x;
            end
        end
    end

endmodule

//--- axis_router.sv
`timescale 1ns/1ns

module axis_router import motion_pkg::*; (
    input  logic [num_motors-1:0][cfg_w-1:0] motor_cfg,
    input  logic [num_channels-1:0]          src_step,
    input  logic [num_channels-1:0]          src_dir,
    input  logic [num_endstops-1:0]         es_hold,
    input  logic [num_endstops-1:0]         es_stb,
    output logic [num_motors-1:0]            mot_step_stb,
    output logic [num_motors-1:0]            mot_dir,
    output logic [num_motors-1:0]            mot_hold,
    output logic [num_motors-1:0]            mot_enable,
    output logic [num_channels-1:0]          es_abort
);

    logic [sel_w-1:0] ch_sel;
    logic [sel_w-1:0] es_sel;

    always_comb begin
        es_abort = '0;
        ch_sel   = '0;
        es_sel   = '0;
        for (int m = 0; m < num_motors; m++) begin
            ch_sel = motor_cfg[m][cfg_src_sel_lsb +: sel_w];
            es_sel = motor_cfg[m][cfg_es_sel_lsb +: sel_w];

            mot_step_stb[m] = src_step[ch_sel] & motor_cfg[m][cfg_step_en];
            mot_dir[m]      = src_dir[ch_sel] ^ motor_cfg[m][cfg_invert_dir];
            mot_hold[m]     = es_hold[es_sel];
            mot_enable[m]   = ~motor_cfg[m][cfg_disable];

            // abort goes back to the channel feeding this motor
            if (motor_cfg[m][cfg_es_abort_en] && es_stb[es_sel]) begin
                es_abort[ch_sel] = 1'b1;
            end
        end
    end

endmodule

//--- endstop_debounce.sv
`timescale 1ns/1ns

module endstop_debounce import motion_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              signal_in,
    input  logic              unlock,
    input  logic [data_w-1:0] timeout,
    output logic              signal,
    output logic              hold,
    output logic              stb
);

    logic [sync_stages-1:0] sync_q;
    logic                   synced;
    logic [data_w-1:0]      cnt;
    logic [data_w-1:0]      cnt_next;
    logic                   take;
    logic                   locked;

    assign synced   = sync_q[sync_stages-1];
    assign cnt_next = cnt + 1'b1;
    // input has differed long enough
    assign take     = (synced != signal) && (cnt_next >= timeout);
    assign hold     = locked;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= '0;
            signal <= 1'b0;
            cnt    <= '0;
            locked <= 1'b0;
            stb    <= 1'b0;
        end else begin
            sync_q <= {sync_q[sync_stages-2:0], signal_in};
            stb    <= 1'b0;

            if (synced != signal) begin
                if (take) begin
                    signal <= synced;
                    cnt    <= '0;
                end else begin
                    cnt <= cnt_next;
                end
            end else begin
                cnt <= '0;  // restart once stable again
            end

            if (take && synced && !locked) begin
                locked <= 1'b1;
                stb    <= 1'b1;  // first assertion only
            end else if (unlock && !signal) begin
                locked <= 1'b0;
            end
        end
    end

endmodule

//--- motion_pkg.sv
package motion_pkg;

    localparam int num_motors   = 4;
    localparam int num_channels = 4;
    localparam int num_endstops = 4;

    localparam int sel_w  = 2;  // endstop / channel select
    localparam int data_w = 32;
    localparam int cfg_w  = 16;

    // motor configuration word layout
    localparam int cfg_es_sel_lsb  = 0;  // 2-bit endstop select
    localparam int cfg_src_sel_lsb = 3;  // 2-bit step channel select
    localparam int cfg_step_en     = 6;
    localparam int cfg_invert_dir  = 7;
    localparam int cfg_es_abort_en = 8;
    localparam int cfg_set_x_en    = 9;
    localparam int cfg_disable     = 15;

    localparam int sync_stages = 2;  // endstop input synchronizer

    typedef enum logic [3:0] {
        reg_pre_n      = 4'd0,
        reg_pulse_n    = 4'd1,
        reg_post_n     = 4'd2,
        reg_es_timeout = 4'd3,
        reg_x_val      = 4'd4,
        reg_motor_cfg0 = 4'd8,
        reg_motor_cfg1 = 4'd9,
        reg_motor_cfg2 = 4'd10,
        reg_motor_cfg3 = 4'd11
    } reg_addr_e;

endpackage
